// ==== design/ex_consts.svh ====
/*
 * Execute stage constants
 * Data, transaction ID and CSR address widths plus PC step sizes
 */

`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Data and address width
`define EX_XLEN 32

// Scoreboard transaction ID width
`define EX_TRANS_ID_BITS 3

// CSR address field width
`define EX_CSR_ADDR_BITS 12

// PC step of a full-size instruction
`define EX_ILEN_STEP 4

// PC step of a compressed instruction
`define EX_CILEN_STEP 2

`endif

// ==== design/ex_pkg.sv ====
/*
 * Execute stage types
 * Opcode of the issued instruction and the CSR buffer state
 */

`default_nettype none

package ex_pkg;

  // ---------------------------------------------------------------------
  // Operation issued to the fixed latency units
  // ---------------------------------------------------------------------
  typedef enum logic [4:0] {
    // ALU
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    // Conditional branches and indirect jump
    EQ,
    NE,
    LTS,
    GES,
    LTU,
    GEU,
    JALR,
    // Multiplier
    MUL,
    MULH,
    MULHU,
    // CSR access
    CSR_READ,
    CSR_WRITE
  } fu_op_e;

  // ---------------------------------------------------------------------
  // CSR address buffer occupancy
  // ---------------------------------------------------------------------
  typedef enum logic {
    CSR_EMPTY,
    CSR_FULL
  } csr_state_e;

endpackage

`default_nettype wire

// ==== design/ex_alu.sv ====
/*
 * ALU
 * Single-cycle arithmetic, logic, shift and compare, plus branch condition
 */

`include "ex_consts.svh"

`default_nettype none

module ex_alu import ex_pkg::*; (
  input  fu_op_e              operator_i,
  input  logic [`EX_XLEN-1:0] operand_a_i,
  input  logic [`EX_XLEN-1:0] operand_b_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                branch_comp_res_o
);

  localparam int ShiftBits = $clog2(`EX_XLEN);

  // Everything but ADD uses the adder as a subtractor
  logic               adder_sub;
  logic [`EX_XLEN:0]  adder_ext;
  logic [`EX_XLEN-1:0] adder_result;
  logic               less_signed;
  logic               less_unsigned;
  logic               equal;
  logic [ShiftBits-1:0] shamt;

  assign adder_sub = (operator_i != ADD);

  // One adder, b inverted plus carry in for subtraction
  assign adder_ext = {1'b0, operand_a_i}
                   + {1'b0, operand_b_i ^ {`EX_XLEN{adder_sub}}}
                   + {{`EX_XLEN{1'b0}}, adder_sub};
  assign adder_result = adder_ext[`EX_XLEN-1:0];

  // No carry out means a borrow, so a < b unsigned
  assign less_unsigned = ~adder_ext[`EX_XLEN];
  // Signs differ -> a negative is less, else look at difference sign
  assign less_signed = (operand_a_i[`EX_XLEN-1] == operand_b_i[`EX_XLEN-1]) ?
                       adder_result[`EX_XLEN-1] : operand_a_i[`EX_XLEN-1];
  assign equal = (adder_result == '0);

  assign shamt = operand_b_i[ShiftBits-1:0];

  // Result select
  always_comb begin
    case (operator_i)
      ADD, SUB: result_o = adder_result;
      AND:      result_o = operand_a_i & operand_b_i;
      OR:       result_o = operand_a_i | operand_b_i;
      XOR:      result_o = operand_a_i ^ operand_b_i;
      SLL:      result_o = operand_a_i << shamt;
      SRL:      result_o = operand_a_i >> shamt;
      SRA:      result_o = $unsigned($signed(operand_a_i) >>> shamt);
      SLT:      result_o = {{(`EX_XLEN-1){1'b0}}, less_signed};
      SLTU:     result_o = {{(`EX_XLEN-1){1'b0}}, less_unsigned};
      default:  result_o = adder_result;
    endcase
  end

  // Branch condition, JALR always taken
  always_comb begin
    case (operator_i)
      EQ:      branch_comp_res_o = equal;
      NE:      branch_comp_res_o = ~equal;
      LTS:     branch_comp_res_o = less_signed;
      GES:     branch_comp_res_o = ~less_signed;
      LTU:     branch_comp_res_o = less_unsigned;
      GEU:     branch_comp_res_o = ~less_unsigned;
      JALR:    branch_comp_res_o = 1'b1;
      default: branch_comp_res_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/ex_branch_unit.sv ====
/*
 * Branch unit
 * Resolves conditional branches and JALR against the front-end prediction
 */

`include "ex_consts.svh"

`default_nettype none

module ex_branch_unit import ex_pkg::*; (
  input  logic                branch_valid_i,
  input  fu_op_e              operator_i,
  input  logic [`EX_XLEN-1:0] operand_a_i,
  input  logic [`EX_XLEN-1:0] imm_i,
  input  logic [`EX_XLEN-1:0] pc_i,
  input  logic                is_compressed_i,
  input  logic                branch_comp_res_i,
  input  logic                predicted_taken_i,
  input  logic [`EX_XLEN-1:0] predicted_target_i,
  output logic [`EX_XLEN-1:0] branch_result_o,
  output logic                resolve_branch_o,
  output logic                resolved_taken_o,
  output logic [`EX_XLEN-1:0] resolved_target_o,
  output logic                mispredict_o
);

  logic [`EX_XLEN-1:0] target_base;
  logic [`EX_XLEN-1:0] target_sum;
  logic [`EX_XLEN-1:0] target;
  logic [`EX_XLEN-1:0] pc_step;
  logic                taken;
  logic                target_wrong;

  // ---------------------------------------------------------------------
  // Target address
  // ---------------------------------------------------------------------
  // JALR jumps relative to rs1, the rest relative to the PC
  assign target_base = (operator_i == JALR) ? operand_a_i : pc_i;
  assign target_sum  = target_base + imm_i;

  // JALR drops the lowest bit of the sum
  assign target = (operator_i == JALR) ?
                  {target_sum[`EX_XLEN-1:1], 1'b0} : target_sum;

  // ---------------------------------------------------------------------
  // Link value
  // ---------------------------------------------------------------------
  assign pc_step = is_compressed_i ? `EX_XLEN'(`EX_CILEN_STEP) :
                                     `EX_XLEN'(`EX_ILEN_STEP);
  // Return address written back to rd
  assign branch_result_o = pc_i + pc_step;

  // ---------------------------------------------------------------------
  // Resolution
  // ---------------------------------------------------------------------
  assign taken = branch_comp_res_i;

  // Only matters if the branch really jumps
  assign target_wrong = taken && (predicted_target_i != target);

  assign resolve_branch_o  = branch_valid_i;
  assign resolved_taken_o  = branch_valid_i & taken;
  assign resolved_target_o = branch_valid_i ? target : '0;

  // Wrong direction or wrong target
  assign mispredict_o = branch_valid_i &
                        ((taken != predicted_taken_i) | target_wrong);

endmodule

`default_nettype wire

// ==== design/ex_csr_buffer.sv ====
/*
 * CSR buffer
 * Holds one CSR address until commit, stalls issue while occupied
 */

`include "ex_consts.svh"

`default_nettype none

module ex_csr_buffer import ex_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         csr_valid_i,
  input  logic                         csr_commit_i,
  input  logic [`EX_XLEN-1:0]          operand_a_i,
  input  logic [`EX_XLEN-1:0]          operand_b_i,
  output logic                         csr_ready_o,
  output logic [`EX_XLEN-1:0]          csr_result_o,
  output logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_o
);

  csr_state_e                   state_q, state_d;
  logic [`EX_CSR_ADDR_BITS-1:0] addr_q;
  logic                         accept;

  // New entry only when the slot is free
  assign accept = csr_valid_i && (state_q == CSR_EMPTY);

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      CSR_EMPTY: if (accept) state_d = CSR_FULL;
      CSR_FULL:  if (csr_commit_i) state_d = CSR_EMPTY;
      default:   state_d = CSR_EMPTY;
    endcase
    // Flush drops a pending entry
    if (flush_i) state_d = CSR_EMPTY;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CSR_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // Address field sits in the low bits of operand b
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= operand_b_i[`EX_CSR_ADDR_BITS-1:0];
    end
  end

  assign csr_ready_o  = (state_q == CSR_EMPTY);
  // rs1 value goes straight to write-back
  assign csr_result_o = operand_a_i;
  assign csr_addr_o   = addr_q;

endmodule

`default_nettype wire

// ==== design/ex_mult.sv ====
/*
 * Multiplier
 * One-cycle MUL, MULH and MULHU with a tagged registered result
 */

`include "ex_consts.svh"

`default_nettype none

module ex_mult import ex_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         mult_valid_i,
  input  fu_op_e                       operator_i,
  input  logic [`EX_XLEN-1:0]          operand_a_i,
  input  logic [`EX_XLEN-1:0]          operand_b_i,
  input  logic [`EX_TRANS_ID_BITS-1:0] trans_id_i,
  output logic [`EX_XLEN-1:0]          mult_result_o,
  output logic                         mult_valid_o,
  output logic [`EX_TRANS_ID_BITS-1:0] mult_trans_id_o
);

  logic                          sign_ext;
  logic [2*`EX_XLEN-1:0]         a_ext;
  logic [2*`EX_XLEN-1:0]         b_ext;
  logic [2*`EX_XLEN-1:0]         product;
  logic [`EX_XLEN-1:0]           half;
  logic                          valid_q;
  logic [`EX_XLEN-1:0]           result_q;
  logic [`EX_TRANS_ID_BITS-1:0]  trans_id_q;

  // Only MULH treats operands as signed
  assign sign_ext = (operator_i == MULH);

  // Extended to full width so the product modulo 2^64 is exact
  assign a_ext = {{`EX_XLEN{sign_ext & operand_a_i[`EX_XLEN-1]}}, operand_a_i};
  assign b_ext = {{`EX_XLEN{sign_ext & operand_b_i[`EX_XLEN-1]}}, operand_b_i};
  assign product = a_ext * b_ext;

  // Low half for MUL, high half otherwise
  assign half = (operator_i == MUL) ? product[`EX_XLEN-1:0] :
                                      product[2*`EX_XLEN-1:`EX_XLEN];

  // Valid flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= mult_valid_i & ~flush_i;
    end
  end

  // Result and tag captured at issue
  always_ff @(posedge clk_i) begin
    if (mult_valid_i) begin
      result_q   <= half;
      trans_id_q <= trans_id_i;
    end
  end

  assign mult_valid_o    = valid_q;
  assign mult_result_o   = result_q;
  assign mult_trans_id_o = trans_id_q;

endmodule

`default_nettype wire

// ==== design/ex_flu_writeback.sv ====
/*
 * Write-back multiplexer
 * Shares one scoreboard write port among the fixed latency units
 */

`include "ex_consts.svh"

`default_nettype none

module ex_flu_writeback (
  input  logic                         alu_valid_i,
  input  logic                         branch_valid_i,
  input  logic                         csr_valid_i,
  input  logic [`EX_XLEN-1:0]          alu_result_i,
  input  logic [`EX_XLEN-1:0]          branch_result_i,
  input  logic [`EX_XLEN-1:0]          csr_result_i,
  input  logic                         csr_ready_i,
  input  logic                         mult_valid_i,
  input  logic [`EX_XLEN-1:0]          mult_result_i,
  input  logic [`EX_TRANS_ID_BITS-1:0] mult_trans_id_i,
  input  logic [`EX_TRANS_ID_BITS-1:0] trans_id_i,
  output logic [`EX_XLEN-1:0]          flu_result_o,
  output logic [`EX_TRANS_ID_BITS-1:0] flu_trans_id_o,
  output logic                         flu_valid_o,
  output logic                         flu_ready_o
);

  // mult_valid_i here is the registered one from the multiplier
  assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid_i;

  // Priority select, link value when nothing else claims the port
  always_comb begin
    flu_result_o   = branch_result_i;
    flu_trans_id_o = trans_id_i;
    if (alu_valid_i) begin
      flu_result_o = alu_result_i;
    end else if (csr_valid_i) begin
      flu_result_o = csr_result_i;
    end else if (mult_valid_i) begin
      // Tag belongs to the instruction issued a cycle earlier
      flu_result_o   = mult_result_i;
      flu_trans_id_o = mult_trans_id_i;
    end
  end

  // Multiplier never stalls, only the CSR slot does
  assign flu_ready_o = csr_ready_i;

endmodule

`default_nettype wire

// ==== design/ex_stage.sv ====
/*
 * Execute stage, fixed latency part
 * ALU, branch unit, CSR buffer and multiplier on one issue and write port
 */

`include "ex_consts.svh"

`default_nettype none

module ex_stage import ex_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  // Issue bundle
  input  fu_op_e                       operator_i,
  input  logic [`EX_XLEN-1:0]          operand_a_i,
  input  logic [`EX_XLEN-1:0]          operand_b_i,
  input  logic [`EX_XLEN-1:0]          imm_i,
  input  logic [`EX_TRANS_ID_BITS-1:0] trans_id_i,
  input  logic [`EX_XLEN-1:0]          pc_i,
  input  logic                         is_compressed_i,
  input  logic                         predicted_taken_i,
  input  logic [`EX_XLEN-1:0]          predicted_target_i,
  input  logic                         alu_valid_i,
  input  logic                         branch_valid_i,
  input  logic                         csr_valid_i,
  input  logic                         mult_valid_i,
  input  logic                         csr_commit_i,
  // Write-back port
  output logic [`EX_XLEN-1:0]          flu_result_o,
  output logic [`EX_TRANS_ID_BITS-1:0] flu_trans_id_o,
  output logic                         flu_valid_o,
  output logic                         flu_ready_o,
  // Branch resolution
  output logic                         resolve_branch_o,
  output logic                         resolved_taken_o,
  output logic [`EX_XLEN-1:0]          resolved_target_o,
  output logic                         mispredict_o,
  // CSR address for the CSR file
  output logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_o
);

  // ---------------------------------------------------------------------
  // Unit outputs
  // ---------------------------------------------------------------------
  logic [`EX_XLEN-1:0]          alu_result;
  logic                         branch_comp_res;
  logic [`EX_XLEN-1:0]          branch_result;
  logic [`EX_XLEN-1:0]          csr_result;
  logic                         csr_ready;
  logic [`EX_XLEN-1:0]          mult_result;
  logic                         mult_valid;
  logic [`EX_TRANS_ID_BITS-1:0] mult_trans_id;

  // ALU, also does the branch compare
  ex_alu i_alu (
    .operator_i,
    .operand_a_i,
    .operand_b_i,
    .result_o          (alu_result),
    .branch_comp_res_o (branch_comp_res)
  );

  // Branch resolution, combinational
  ex_branch_unit i_branch_unit (
    .branch_valid_i,
    .operator_i,
    .operand_a_i,
    .imm_i,
    .pc_i,
    .is_compressed_i,
    .branch_comp_res_i  (branch_comp_res),
    .predicted_taken_i,
    .predicted_target_i,
    .branch_result_o    (branch_result),
    .resolve_branch_o,
    .resolved_taken_o,
    .resolved_target_o,
    .mispredict_o
  );

  // Single-entry CSR slot
  ex_csr_buffer i_csr_buffer (
    .clk_i,
    .rst_ni,
    .flush_i,
    .csr_valid_i,
    .csr_commit_i,
    .operand_a_i,
    .operand_b_i,
    .csr_ready_o  (csr_ready),
    .csr_result_o (csr_result),
    .csr_addr_o
  );

  // Multiplier, result one cycle later
  ex_mult i_mult (
    .clk_i,
    .rst_ni,
    .flush_i,
    .mult_valid_i,
    .operator_i,
    .operand_a_i,
    .operand_b_i,
    .trans_id_i,
    .mult_result_o   (mult_result),
    .mult_valid_o    (mult_valid),
    .mult_trans_id_o (mult_trans_id)
  );

  // Shared write-back port
  ex_flu_writeback i_flu_writeback (
    .alu_valid_i,
    .branch_valid_i,
    .csr_valid_i,
    .alu_result_i    (alu_result),
    .branch_result_i (branch_result),
    .csr_result_i    (csr_result),
    .csr_ready_i     (csr_ready),
    .mult_valid_i    (mult_valid),
    .mult_result_i   (mult_result),
    .mult_trans_id_i (mult_trans_id),
    .trans_id_i,
    .flu_result_o,
    .flu_trans_id_o,
    .flu_valid_o,
    .flu_ready_o
  );

endmodule

`default_nettype wire

// ==== verification/ex_stage_sva.sv ====
/*
 * Execute stage protocol assertions
 * Issue rules and multiplier latency, bound into the stage
 */

`default_nettype none

module ex_stage_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic flush_i,
  input logic alu_valid_i,
  input logic branch_valid_i,
  input logic csr_valid_i,
  input logic mult_valid_i,
  input logic flu_valid_o,
  input logic flu_ready_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // CSR issue only into a free slot
  csr_issue_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_valid_i |-> flu_ready_o)
    else $error("CSR issued while the stage was not ready");

  // Single issue port
  one_unit_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i}))
    else $error("More than one unit valid in the same cycle");

  // Write-back slot after a multiply belongs to the multiplier
  mult_slot_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mult_valid_i |=> !(alu_valid_i || branch_valid_i || csr_valid_i))
    else $error("Issue collided with a multiplier result");

  // Fixed one-cycle multiplier latency, unless flushed
  mult_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mult_valid_i && !flush_i) |=> flu_valid_o)
    else $error("Multiplier result missing one cycle after issue");

endmodule

bind ex_stage ex_stage_sva i_sva (.*);

`default_nettype wire

// ==== verification/ex_stage_tb.sv ====
/*
 * Execute stage testbench
 * Table-driven ALU and branch checks, CSR buffer and multiplier sequences
 */

`include "ex_consts.svh"

`default_nettype none

module ex_stage_tb import ex_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          ClkPeriod    = 100;
  localparam int          SampleDelay  = 25;
  localparam int          ReadyTimeout = 20;
  localparam int          NumMults     = 6;
  localparam logic [31:0] BranchPc     = 32'h0000_1000;
  localparam logic [31:0] LfsrSeed     = 32'hc5e6fb56;

  // One row of the ALU and branch table
  typedef struct {
    string       name;
    fu_op_e      op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic        compressed;
    logic        pred_taken;
    logic [31:0] pred_target;
    logic        is_branch;
    logic [31:0] exp_result;
    logic        exp_taken;
    logic [31:0] exp_target;
    logic        exp_mispredict;
  } vector_t;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         flush_i;
  fu_op_e                       operator_i;
  logic [`EX_XLEN-1:0]          operand_a_i;
  logic [`EX_XLEN-1:0]          operand_b_i;
  logic [`EX_XLEN-1:0]          imm_i;
  logic [`EX_TRANS_ID_BITS-1:0] trans_id_i;
  logic [`EX_XLEN-1:0]          pc_i;
  logic                         is_compressed_i;
  logic                         predicted_taken_i;
  logic [`EX_XLEN-1:0]          predicted_target_i;
  logic                         alu_valid_i;
  logic                         branch_valid_i;
  logic                         csr_valid_i;
  logic                         mult_valid_i;
  logic                         csr_commit_i;
  logic [`EX_XLEN-1:0]          flu_result_o;
  logic [`EX_TRANS_ID_BITS-1:0] flu_trans_id_o;
  logic                         flu_valid_o;
  logic                         flu_ready_o;
  logic                         resolve_branch_o;
  logic                         resolved_taken_o;
  logic [`EX_XLEN-1:0]          resolved_target_o;
  logic                         mispredict_o;
  logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_o;

  vector_t     vectors[$];
  logic [31:0] lfsr_state;
  int          checks;
  int          errors;
  int          timeouts;

  ex_stage dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // ---------------------------------------------------------------------
  // Stimulus helpers and reference models
  // ---------------------------------------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = '0;
    for (int k = 0; k < 32; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
    return w;
  endfunction

  // Low half for MUL, signed or unsigned high half otherwise
  function automatic logic [31:0] mult_model(input fu_op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
    logic signed [63:0] sp;
    logic        [63:0] up;
    sp = 64'($signed(a)) * 64'($signed(b));
    up = {32'h0, a} * {32'h0, b};
    case (op)
      MUL:     return up[31:0];
      MULH:    return sp[63:32];
      default: return up[63:32];
    endcase
  endfunction

  // Link value is pc plus the instruction size
  function automatic vector_t branch_case(input string name, input fu_op_e op,
      input logic [31:0] a, input logic [31:0] b, input logic [31:0] imm,
      input logic compressed, input logic pred_taken, input logic [31:0] pred_target,
      input logic exp_taken, input logic [31:0] exp_target, input logic exp_mispredict);
    vector_t v;
    v.name           = name;
    v.op             = op;
    v.a              = a;
    v.b              = b;
    v.imm            = imm;
    v.compressed     = compressed;
    v.pred_taken     = pred_taken;
    v.pred_target    = pred_target;
    v.is_branch      = 1'b1;
    v.exp_result     = BranchPc + (compressed ? 32'd2 : 32'd4);
    v.exp_taken      = exp_taken;
    v.exp_target     = exp_target;
    v.exp_mispredict = exp_mispredict;
    return v;
  endfunction

  function automatic vector_t alu_case(input string name, input fu_op_e op,
      input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp_result);
    vector_t v;
    v = branch_case(name, op, a, b, '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
    v.is_branch  = 1'b0;
    v.exp_result = exp_result;
    return v;
  endfunction

  task automatic build_table();
    vectors.push_back(alu_case("add", ADD, 32'h0000_1234, 32'h0000_0f00, 32'h0000_2134));
    vectors.push_back(alu_case("sub", SUB, 32'h5, 32'h7, 32'hffff_fffe));
    vectors.push_back(alu_case("and", AND, 32'hf0f0_00ff, 32'h0ff0_0f0f, 32'h00f0_000f));
    vectors.push_back(alu_case("or", OR, 32'hf0f0_00ff, 32'h0ff0_0f0f, 32'hfff0_0fff));
    vectors.push_back(alu_case("xor", XOR, 32'hf0f0_00ff, 32'h0ff0_0f0f, 32'hff00_0ff0));
    // Only the low five bits of b count as shift amount
    vectors.push_back(alu_case("sll", SLL, 32'h0000_0081, 32'h0000_0024, 32'h0000_0810));
    vectors.push_back(alu_case("srl", SRL, 32'h8000_0010, 32'h4, 32'h0800_0001));
    vectors.push_back(alu_case("sra", SRA, 32'h8000_0010, 32'h4, 32'hf800_0001));
    vectors.push_back(alu_case("slt", SLT, 32'hffff_ffff, 32'h1, 32'h1));
    vectors.push_back(alu_case("slt_pos", SLT, 32'h1, 32'h8000_0000, 32'h0));
    vectors.push_back(alu_case("sltu", SLTU, 32'hffff_ffff, 32'h1, 32'h0));
    // name, op, a, b, imm, compressed, prediction, then taken, target, mispredict
    vectors.push_back(branch_case("eq_taken", EQ, 32'h7, 32'h7, 32'h40,
                                  1'b0, 1'b1, 32'h1040, 1'b1, 32'h1040, 1'b0));
    vectors.push_back(branch_case("eq_not_taken", EQ, 32'h7, 32'h8, 32'h40,
                                  1'b0, 1'b0, 32'h0, 1'b0, 32'h1040, 1'b0));
    vectors.push_back(branch_case("ne_wrong_dir_c", NE, 32'h1, 32'h2, 32'h40,
                                  1'b1, 1'b0, 32'h0, 1'b1, 32'h1040, 1'b1));
    vectors.push_back(branch_case("lts_wrong_target", LTS, 32'hffff_fffe, 32'h3, 32'h40,
                                  1'b0, 1'b1, 32'h1044, 1'b1, 32'h1040, 1'b1));
    vectors.push_back(branch_case("ges_back_not_taken", GES, 32'hffff_fffe, 32'h3,
                                  32'hffff_ff80, 1'b0, 1'b1, 32'h0f80, 1'b0, 32'h0f80, 1'b1));
    vectors.push_back(branch_case("ltu_not_taken_c", LTU, 32'hffff_fffe, 32'h3, 32'h40,
                                  1'b1, 1'b0, 32'h0, 1'b0, 32'h1040, 1'b0));
    vectors.push_back(branch_case("geu_taken", GEU, 32'hffff_fffe, 32'h3, 32'h40,
                                  1'b0, 1'b1, 32'h1040, 1'b1, 32'h1040, 1'b0));
    // JALR target is rs1 plus imm with bit 0 cleared
    vectors.push_back(branch_case("jalr_taken", JALR, 32'h2001, 32'h0, 32'h10,
                                  1'b0, 1'b1, 32'h2010, 1'b1, 32'h2010, 1'b0));
    vectors.push_back(branch_case("jalr_neg_imm_c", JALR, 32'h3000, 32'h0, 32'hffff_fff3,
                                  1'b1, 1'b0, 32'h0, 1'b1, 32'h2ff2, 1'b1));
  endtask

  // ---------------------------------------------------------------------
  // Drive, check and wait
  // ---------------------------------------------------------------------
  task automatic clear_issue();
    operator_i         = ADD;
    operand_a_i        = '0;
    operand_b_i        = '0;
    imm_i              = '0;
    trans_id_i         = '0;
    pc_i               = '0;
    is_compressed_i    = 1'b0;
    predicted_taken_i  = 1'b0;
    predicted_target_i = '0;
    alu_valid_i        = 1'b0;
    branch_valid_i     = 1'b0;
    csr_valid_i        = 1'b0;
    mult_valid_i       = 1'b0;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Polls ready at each falling edge until high or timed out
  task automatic wait_for_ready(input string what);
    int cycles;
    cycles = 0;
    while (!flu_ready_o && cycles < ReadyTimeout) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!flu_ready_o) begin
      timeouts++;
      $display("Timeout: flu_ready_o still low after %0d cycles %s", cycles, what);
    end
  endtask

  // Issue, same-cycle result, then slot occupied with the latched address
  task automatic issue_csr(input string name, input fu_op_e op, input logic [31:0] a,
                           input logic [31:0] b, input logic [2:0] tid,
                           input logic [11:0] exp_addr);
    wait_for_ready({"before ", name});
    @(negedge clk_i);
    operator_i  = op;
    operand_a_i = a;
    operand_b_i = b;
    trans_id_i  = tid;
    csr_valid_i = 1'b1;
    #SampleDelay;
    check_value({name, " valid"}, 32'h1, 32'(flu_valid_o));
    check_value({name, " result"}, a, flu_result_o);
    check_value({name, " trans_id"}, 32'(tid), 32'(flu_trans_id_o));
    @(negedge clk_i);
    clear_issue();
    #SampleDelay;
    check_value({name, " ready while full"}, 32'h0, 32'(flu_ready_o));
    check_value({name, " address"}, 32'(exp_addr), 32'(csr_addr_o));
  endtask

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------
  initial begin
    vector_t     v;
    fu_op_e      op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_products[$];
    logic [2:0]  exp_tags[$];

    clear_issue();
    rst_ni       = 1'b1;
    flush_i      = 1'b0;
    csr_commit_i = 1'b0;
    checks       = 0;
    errors       = 0;
    timeouts     = 0;
    lfsr_state   = LfsrSeed;
    build_table();

    @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    #SampleDelay;
    check_value("reset flu_valid_o", 32'h0, 32'(flu_valid_o));
    check_value("reset resolve_branch_o", 32'h0, 32'(resolve_branch_o));
    check_value("reset mispredict_o", 32'h0, 32'(mispredict_o));
    check_value("reset flu_ready_o", 32'h1, 32'(flu_ready_o));

    // One table row issued per cycle
    foreach (vectors[i]) begin
      v = vectors[i];
      @(negedge clk_i);
      operator_i         = v.op;
      operand_a_i        = v.a;
      operand_b_i        = v.b;
      imm_i              = v.imm;
      pc_i               = BranchPc;
      is_compressed_i    = v.compressed;
      predicted_taken_i  = v.pred_taken;
      predicted_target_i = v.pred_target;
      trans_id_i         = 3'(i);
      alu_valid_i        = !v.is_branch;
      branch_valid_i     = v.is_branch;
      #SampleDelay;
      check_value({v.name, " valid"}, 32'h1, 32'(flu_valid_o));
      check_value({v.name, " result"}, v.exp_result, flu_result_o);
      check_value({v.name, " trans_id"}, 32'(i % 8), 32'(flu_trans_id_o));
      check_value({v.name, " resolve"}, 32'(v.is_branch), 32'(resolve_branch_o));
      check_value({v.name, " mispredict"}, 32'(v.exp_mispredict), 32'(mispredict_o));
      if (v.is_branch) begin
        check_value({v.name, " taken"}, 32'(v.exp_taken), 32'(resolved_taken_o));
        check_value({v.name, " target"}, v.exp_target, resolved_target_o);
      end
    end
    @(negedge clk_i);
    clear_issue();

    // CSR slot freed by commit
    issue_csr("csr_write", CSR_WRITE, 32'hcafe_0001, 32'h0000_5305, 3'd5, 12'h305);
    @(negedge clk_i);
    csr_commit_i = 1'b1;
    #SampleDelay;
    check_value("csr_write ready before commit edge", 32'h0, 32'(flu_ready_o));
    @(negedge clk_i);
    csr_commit_i = 1'b0;
    wait_for_ready("after commit");

    // CSR slot freed by flush
    issue_csr("csr_read", CSR_READ, 32'h1234_5678, 32'hffff_fc00, 3'd2, 12'hc00);
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    wait_for_ready("after flush");

    // Back-to-back multiplies checked one cycle after each issue
    for (int i = 0; i <= NumMults; i++) begin
      @(negedge clk_i);
      if (i < NumMults) begin
        a = random_word();
        b = random_word();
        case (i % 3)
          0:       op = MUL;
          1:       op = MULH;
          default: op = MULHU;
        endcase
        operator_i   = op;
        operand_a_i  = a;
        operand_b_i  = b;
        trans_id_i   = 3'(i + 1);
        mult_valid_i = 1'b1;
        exp_products.push_back(mult_model(op, a, b));
        exp_tags.push_back(3'(i + 1));
      end else begin
        clear_issue();
      end
      #SampleDelay;
      if (i > 0) begin
        check_value($sformatf("mult %0d valid", i - 1), 32'h1, 32'(flu_valid_o));
        check_value($sformatf("mult %0d result", i - 1), exp_products.pop_front(),
                    flu_result_o);
        check_value($sformatf("mult %0d trans_id", i - 1), 32'(exp_tags.pop_front()),
                    32'(flu_trans_id_o));
      end
    end
    @(negedge clk_i);
    #SampleDelay;
    check_value("mult drained", 32'h0, 32'(flu_valid_o));

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/ex_pkg.sv
design/ex_alu.sv
design/ex_branch_unit.sv
design/ex_csr_buffer.sv
design/ex_mult.sv
design/ex_flu_writeback.sv
design/ex_stage.sv
verification/ex_stage_sva.sv
verification/ex_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the execute stage testbench with Verilator, run it, check the log
cd "$(dirname "$0")" \
  && verilator --binary --assert --timescale 1ns/1ps --top-module ex_stage_tb \
       -f files.f -Mdir obj_dir -o ex_stage_tb \
  && ./obj_dir/ex_stage_tb > sim.log 2>&1 \
  && ! grep -q "Simulation FAILED" sim.log \
  && grep -q "Simulation PASSED" sim.log \
  && echo "Run passed, see sim.log" \
  || { echo "Run failed, see sim.log"; exit 1; }
